// File: hdl/exec_pkg.sv
// Shared types of the execute stage: word and index types, the operation enum,
// the issue request, the writeback response and the controller state
`default_nettype none

package exec_pkg;

    // Machine word for operands, results, addresses and the immediate
    typedef logic [31:0] word_t;

    // Register file index
    typedef logic [4:0] reg_addr_t;

    // Shift amount, taken from the low bits of operand B
    typedef logic [4:0] shamt_t;

    // Operations executed by the stage, already decoded upstream
    typedef enum logic [4:0] {
        ADD, SUB, ADDI,
        SLT, SLTI, SLTU, SLTIU,
        AND, ANDI, OR, ORI, XOR, XORI,
        SLL, SLLI, SRL, SRLI, SRA, SRAI,
        LUI, AUIPC,
        JAL, JALR,
        BEQ, BNE, BLT, BLTU, BGE, BGEU
    } alu_operation_t;

    // Issued instruction as it arrives from decode and register read
    typedef struct packed {
        alu_operation_t operation;
        word_t          rs1;
        word_t          rs2;
        word_t          imm;
        word_t          pc;
        reg_addr_t      rd;
        logic           compressed;
    } exec_req_t;

    // Writeback and redirect information of one executed instruction
    typedef struct packed {
        reg_addr_t rd;
        word_t     result;
        logic      write_en;
        logic      redirect;
        word_t     target;
        logic      misaligned;
    } exec_resp_t;

    // Occupancy of the single response slot
    typedef enum logic {
        EMPTY,
        FULL
    } ctrl_state_t;

endpackage : exec_pkg

`default_nettype wire

// File: hdl/operand_select.sv
// Operand selection of the execute stage
// Operand A comes from rs1 or the pc, operand B from rs2 or the immediate
`timescale 1ns/10ps
`default_nettype none

module operand_select (
    input  exec_pkg::exec_req_t req_i,
    output exec_pkg::word_t     operand_a_o,
    output exec_pkg::word_t     operand_b_o
);

    import exec_pkg::*;

    logic use_pc;
    logic use_imm;

    // Only AUIPC adds to the instruction address inside the ALU
    // Jump targets are formed in the branch resolver, not here
    assign use_pc = (req_i.operation == AUIPC);

    // Immediate forms, upper immediates and JALR take the immediate
    // Conditional branches compare rs1 against rs2, so they keep rs2
    always_comb begin : imm_decode
        case (req_i.operation)
            ADDI, SLTI, SLTIU,
            ANDI, ORI, XORI,
            SLLI, SRLI, SRAI,
            LUI, AUIPC, JALR: use_imm = 1'b1;
            default:          use_imm = 1'b0;
        endcase
    end : imm_decode

    // Operand A mux
    assign operand_a_o = use_pc ? req_i.pc : req_i.rs1;

    // Operand B mux
    // The SLTIU immediate is already sign-extended by decode
    assign operand_b_o = use_imm ? req_i.imm : req_i.rs2;

endmodule : operand_select

`default_nettype wire

// File: hdl/arithmetic_logic_unit.sv
// Combinational RV32I ALU: adder, comparators, shifter, logic unit,
// link address and branch condition
`timescale 1ns/10ps
`default_nettype none

module arithmetic_logic_unit #(
    parameter bit C_EXT_EN = 1'b1
) (
    input  exec_pkg::word_t          operand_a_i,
    input  exec_pkg::word_t          operand_b_i,
    input  exec_pkg::word_t          pc_i,
    input  exec_pkg::alu_operation_t operation_i,
    input  logic                     is_compressed_i,
    output exec_pkg::word_t          result_o,
    output logic                     branch_taken_o,
    output logic                     is_branch_o
);

    import exec_pkg::*;

    // --------------------
    // Adder
    // --------------------

    logic  is_sub;
    word_t adder_b;
    word_t adder_result;

    // Subtraction reuses the adder as a + ~b + 1
    assign is_sub       = (operation_i == SUB);
    assign adder_b      = is_sub ? ~operand_b_i : operand_b_i;
    assign adder_result = operand_a_i + adder_b + {31'b0, is_sub};

    // --------------------
    // Comparators
    // --------------------

    logic is_equal;
    logic less_signed;
    logic less_unsigned;

    // One comparator pair serves both the set-less-than and the branch forms
    assign is_equal      = (operand_a_i == operand_b_i);
    assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
    assign less_unsigned = (operand_a_i < operand_b_i);

    // Branch condition and jump flag
    always_comb begin : branch_condition
        is_branch_o    = 1'b1;
        branch_taken_o = 1'b0;
        case (operation_i)
            JAL, JALR: branch_taken_o = 1'b1;
            BEQ:       branch_taken_o = is_equal;
            BNE:       branch_taken_o = ~is_equal;
            BLT:       branch_taken_o = less_signed;
            BLTU:      branch_taken_o = less_unsigned;
            BGE:       branch_taken_o = ~less_signed;
            BGEU:      branch_taken_o = ~less_unsigned;
            default:   is_branch_o    = 1'b0;
        endcase
    end : branch_condition

    // --------------------
    // Shifter
    // --------------------

    shamt_t shamt;
    word_t  sll_result;
    word_t  srl_result;
    word_t  sra_result;

    // Only the low five bits of the register or immediate count
    assign shamt      = operand_b_i[4:0];
    assign sll_result = operand_a_i << shamt;
    assign srl_result = operand_a_i >> shamt;
    assign sra_result = $signed(operand_a_i) >>> shamt;

    // Link address for JAL and JALR
    // A compressed jump is two bytes long, but only with the C extension
    word_t link_addr;
    assign link_addr = (C_EXT_EN && is_compressed_i) ? pc_i + 32'd2 : pc_i + 32'd4;

    // --------------------
    // Result mux
    // --------------------

    always_comb begin : result_mux
        case (operation_i)
            ADD, ADDI, SUB, AUIPC: result_o = adder_result;
            SLT, SLTI:             result_o = {31'b0, less_signed};
            SLTU, SLTIU:           result_o = {31'b0, less_unsigned};
            AND, ANDI:             result_o = operand_a_i & operand_b_i;
            OR, ORI:               result_o = operand_a_i | operand_b_i;
            XOR, XORI:             result_o = operand_a_i ^ operand_b_i;
            SLL, SLLI:             result_o = sll_result;
            SRL, SRLI:             result_o = srl_result;
            SRA, SRAI:             result_o = sra_result;
            LUI:                   result_o = operand_b_i;
            JAL, JALR:             result_o = link_addr;
            // Conditional branches write nothing back
            default:               result_o = '0;
        endcase
    end : result_mux

endmodule : arithmetic_logic_unit

`default_nettype wire

// File: hdl/branch_resolver.sv
// Branch and jump resolution: target address, redirect and the
// misaligned-target flag
`timescale 1ns/10ps
`default_nettype none

module branch_resolver #(
    parameter bit C_EXT_EN = 1'b1
) (
    input  exec_pkg::exec_req_t req_i,
    input  logic                branch_taken_i,
    output exec_pkg::word_t     target_o,
    output logic                redirect_o,
    output logic                misaligned_o
);

    import exec_pkg::*;

    logic  is_jalr;
    word_t target_base;
    word_t target_sum;

    // JALR is register relative, every other transfer is pc relative
    assign is_jalr     = (req_i.operation == JALR);
    assign target_base = is_jalr ? req_i.rs1 : req_i.pc;

    // Own adder, so the ALU comparator and the target settle in the same cycle
    assign target_sum = target_base + req_i.imm;

    // JALR drops bit 0 of the sum
    assign target_o = is_jalr ? {target_sum[31:1], 1'b0} : target_sum;

    // Any taken branch or jump redirects fetch
    assign redirect_o = branch_taken_i;

    // Without the C extension targets must be word aligned
    assign misaligned_o = !C_EXT_EN && redirect_o && target_o[1];

endmodule : branch_resolver

`default_nettype wire

// File: hdl/execute_control.sv
// Issue and hold controller: valid/ready handshake with a one-entry
// response register
`timescale 1ns/10ps
`default_nettype none

module execute_control (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  logic                 resp_ready_i,
    input  exec_pkg::exec_req_t  req_i,
    input  exec_pkg::word_t      result_i,
    input  logic                 is_branch_i,
    input  exec_pkg::word_t      target_i,
    input  logic                 redirect_i,
    input  logic                 misaligned_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output exec_pkg::exec_resp_t resp_o
);

    import exec_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    exec_resp_t  resp_d;
    exec_resp_t  resp_q;
    logic        accept;
    logic        cond_branch;

    // --------------------
    // Handshake
    // --------------------

    // The slot can take a new item when empty or when it drains this cycle
    assign req_ready_o  = (state_q == EMPTY) || resp_ready_i;
    assign accept       = req_valid_i && req_ready_o;
    assign resp_valid_o = (state_q == FULL);

    always_comb begin : next_state
        state_d = state_q;
        case (state_q)
            EMPTY: if (accept) state_d = FULL;
            FULL:  if (resp_ready_i && !accept) state_d = EMPTY;
            default: state_d = EMPTY;
        endcase
    end : next_state

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Response register
    // --------------------

    // The ALU flags jumps too, so exclude them to find conditional branches
    assign cond_branch = is_branch_i && !(req_i.operation inside {JAL, JALR});

    always_comb begin : build_resp
        resp_d.rd         = req_i.rd;
        resp_d.result     = result_i;
        // Writes to x0 are dropped, and conditional branches never write
        resp_d.write_en   = (req_i.rd != '0) && !cond_branch;
        resp_d.redirect   = redirect_i;
        resp_d.target     = target_i;
        resp_d.misaligned = misaligned_i;
    end : build_resp

    // Loaded only on acceptance, so a stalled response stays put
    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_q <= resp_d;
        end
    end

    assign resp_o = resp_q;

endmodule : execute_control

`default_nettype wire

// File: hdl/execute_unit.sv
// Top level of the integer execute stage: operand selection, ALU,
// branch resolver and issue/hold controller
`timescale 1ns/10ps
`default_nettype none

module execute_unit #(
    parameter bit C_EXT_EN = 1'b1
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  exec_pkg::exec_req_t  req_i,
    input  logic                 resp_ready_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output exec_pkg::exec_resp_t resp_o
);

    import exec_pkg::*;

    word_t operand_a;
    word_t operand_b;
    word_t alu_result;
    logic  branch_taken;
    logic  is_branch;
    word_t target;
    logic  redirect;
    logic  misaligned;

    // Operand muxes in front of the ALU
    operand_select u_operand_select (
        .req_i       (req_i),
        .operand_a_o (operand_a),
        .operand_b_o (operand_b)
    );

    // Result, link address and branch condition
    arithmetic_logic_unit #(
        .C_EXT_EN (C_EXT_EN)
    ) u_alu (
        .operand_a_i     (operand_a),
        .operand_b_i     (operand_b),
        .pc_i            (req_i.pc),
        .operation_i     (req_i.operation),
        .is_compressed_i (req_i.compressed),
        .result_o        (alu_result),
        .branch_taken_o  (branch_taken),
        .is_branch_o     (is_branch)
    );

    // Target address in parallel with the ALU comparison
    branch_resolver #(
        .C_EXT_EN (C_EXT_EN)
    ) u_branch_resolver (
        .req_i          (req_i),
        .branch_taken_i (branch_taken),
        .target_o       (target),
        .redirect_o     (redirect),
        .misaligned_o   (misaligned)
    );

    // One-cycle registered response behind the handshake
    execute_control u_execute_control (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .resp_ready_i (resp_ready_i),
        .req_i        (req_i),
        .result_i     (alu_result),
        .is_branch_i  (is_branch),
        .target_i     (target),
        .redirect_i   (redirect),
        .misaligned_i (misaligned),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

endmodule : execute_unit

`default_nettype wire

// File: tb/execute_unit_properties.sv
// Handshake and reset assertions for the execute stage, bound to execute_unit
`timescale 1ns/10ps
`default_nettype none

module execute_unit_properties (
    input wire logic                 clk_i,
    input wire logic                 rst_n_i,
    input wire logic                 req_ready_i,
    input wire logic                 resp_valid_i,
    input wire logic                 resp_ready_i,
    input wire exec_pkg::exec_resp_t resp_i
);

    // Failures seen so far, read by the testbench scoreboard
    int unsigned failure_count = 0;

    // No response may be offered while reset is applied
    reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !resp_valid_i)
        else begin
            $error("resp_valid_o high during reset");
            failure_count++;
        end

    // A stalled response keeps its valid and its payload
    stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
        else begin
            $error("resp_o changed while stalled");
            failure_count++;
        end

    // An empty output slot always accepts
    ready_when_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !resp_valid_i |-> req_ready_i)
        else begin
            $error("req_ready_o low with an empty slot");
            failure_count++;
        end

endmodule : execute_unit_properties

bind execute_unit execute_unit_properties u_properties (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_ready_i  (req_ready_o),
    .resp_valid_i (resp_valid_o),
    .resp_ready_i (resp_ready_i),
    .resp_i       (resp_o)
);

`default_nettype wire

// File: tb/execute_unit_tb.sv
// Testbench of the execute stage: directed and LCG stimulus, reference model,
// in-order scoreboard with one-cycle latency check, and a watchdog
`timescale 1ns/10ps
`default_nettype none

module execute_unit_tb #(
    parameter bit C_EXT_EN = 1'b1
);

    import exec_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 500;

    logic       clk_i;
    logic       rst_n_i;
    logic       req_valid_i;
    exec_req_t  req_i;
    logic       resp_ready_i;
    logic       req_ready_o;
    logic       resp_valid_o;
    exec_resp_t resp_o;

    word_t      lcg_state = 32'd86;
    exec_req_t  stim_q[$];
    exec_resp_t exp_q[$];
    string      name_q[$];
    logic       req_fire      = 1'b0;
    logic       accepted_last = 1'b0;
    logic       stim_ready    = 1'b0;
    int         push_count    = 0;
    int         resp_count    = 0;

    execute_unit #(
        .C_EXT_EN (C_EXT_EN)
    ) DUT (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .resp_ready_i (resp_ready_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // Random numbers and stimulus
    // --------------------

    // Halves are swapped so that the weak low bits of the LCG are not used directly
    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    task automatic add_request(input alu_operation_t op, input word_t rs1, input word_t rs2,
                               input word_t imm, input word_t pc, input reg_addr_t rd,
                               input logic compressed);
        exec_req_t req;
        req.operation  = op;
        req.rs1        = rs1;
        req.rs2        = rs2;
        req.imm        = imm;
        req.pc         = pc;
        req.rd         = rd;
        req.compressed = compressed;
        stim_q.push_back(req);
    endtask

    function automatic exec_req_t random_request();
        exec_req_t  req;
        word_t      rnd;
        logic [4:0] op_index;
        rnd            = next_random();
        op_index       = 5'(rnd % 32'd29);
        req.operation  = alu_operation_t'(op_index);
        req.rd         = rnd[20:16];
        req.compressed = rnd[24];
        req.rs1        = next_random();
        // Every sixteenth request compares equal operands so BEQ and BGE get taken
        req.rs2        = (rnd[27:24] == 4'h0) ? req.rs1 : next_random();
        rnd            = next_random();
        req.imm        = {{20{rnd[11]}}, rnd[11:0]};
        if (req.operation inside {LUI, AUIPC}) begin
            req.imm = {rnd[31:12], 12'b0};
        end
        rnd    = next_random();
        req.pc = {rnd[31:1], 1'b0};
        return req;
    endfunction

    // --------------------
    // Reference model
    // --------------------

    // Expected response built from the stage rules alone
    function automatic exec_resp_t expected_response(input exec_req_t req);
        exec_resp_t resp;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      res;
        logic       taken;
        logic       cond;
        a     = req.rs1;
        b     = req.rs2;
        imm   = req.imm;
        res   = '0;
        taken = 1'b0;
        cond  = 1'b0;
        case (req.operation)
            ADD:   res = a + b;
            SUB:   res = a - b;
            ADDI:  res = a + imm;
            SLT:   res = {31'b0, $signed(a) < $signed(b)};
            SLTI:  res = {31'b0, $signed(a) < $signed(imm)};
            SLTU:  res = {31'b0, a < b};
            SLTIU: res = {31'b0, a < imm};
            AND:   res = a & b;
            ANDI:  res = a & imm;
            OR:    res = a | b;
            ORI:   res = a | imm;
            XOR:   res = a ^ b;
            XORI:  res = a ^ imm;
            SLL:   res = a << b[4:0];
            SLLI:  res = a << imm[4:0];
            SRL:   res = a >> b[4:0];
            SRLI:  res = a >> imm[4:0];
            SRA:   res = word_t'($signed(a) >>> b[4:0]);
            SRAI:  res = word_t'($signed(a) >>> imm[4:0]);
            LUI:   res = imm;
            AUIPC: res = req.pc + imm;
            JAL, JALR: begin
                taken = 1'b1;
                res   = (C_EXT_EN && req.compressed) ? req.pc + 32'd2 : req.pc + 32'd4;
            end
            BEQ:  begin cond = 1'b1; taken = (a == b); end
            BNE:  begin cond = 1'b1; taken = (a != b); end
            BLT:  begin cond = 1'b1; taken = ($signed(a) < $signed(b)); end
            BLTU: begin cond = 1'b1; taken = (a < b); end
            BGE:  begin cond = 1'b1; taken = ($signed(a) >= $signed(b)); end
            BGEU: begin cond = 1'b1; taken = (a >= b); end
            default: res = '0;
        endcase
        resp.rd       = req.rd;
        resp.result   = res;
        resp.write_en = !cond && (req.rd != 5'd0);
        resp.redirect = taken;
        if (req.operation == JALR) begin
            resp.target = (a + imm) & ~32'd1;
        end else begin
            resp.target = req.pc + imm;
        end
        resp.misaligned = !C_EXT_EN && taken && resp.target[1];
        return resp;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "Execute stage testbench stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected x%0d, actual x%0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // Samples at the falling edge, where inputs and outputs are settled
    always @(negedge clk_i) begin : scoreboard
        exec_resp_t     expected;
        string          name;
        alu_operation_t op;
        if (!rst_n_i) begin
            req_fire      = 1'b0;
            accepted_last = 1'b0;
        end else begin
            if (DUT.u_properties.failure_count != 0) begin
                $display("A handshake assertion on the execute unit failed");
                abort_run();
            end
            if (accepted_last && !resp_valid_o) begin
                $display("No response one cycle after request %0d was accepted", push_count - 1);
                abort_run();
            end
            // The slot is occupied exactly while an accepted response waits in the queue
            check_flag("handshake req_ready_o", (exp_q.size() == 0) || resp_ready_i,
                       req_ready_o);
            // The response on the output is compared before a new one is queued
            if (resp_valid_o && resp_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("The DUT delivered a response that no request asked for");
                    abort_run();
                end
                expected = exp_q.pop_front();
                name     = name_q.pop_front();
                check_reg({name, " rd"}, expected.rd, resp_o.rd);
                check_word({name, " result"}, expected.result, resp_o.result);
                check_flag({name, " write_en"}, expected.write_en, resp_o.write_en);
                check_flag({name, " redirect"}, expected.redirect, resp_o.redirect);
                check_word({name, " target"}, expected.target, resp_o.target);
                check_flag({name, " misaligned"}, expected.misaligned, resp_o.misaligned);
                resp_count++;
            end
            req_fire      = req_valid_i && req_ready_o;
            accepted_last = req_fire;
            if (req_fire) begin
                op = req_i.operation;
                exp_q.push_back(expected_response(req_i));
                name_q.push_back($sformatf("#%0d %s", push_count, op.name()));
                push_count++;
            end
        end
    end : scoreboard

    // Allows four cycles per request on top of the reset time
    initial begin : watchdog
        int timeout_ns;
        wait (stim_ready);
        timeout_ns = stim_q.size() * 4 * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;
        #(timeout_ns);
        $display("The run timed out after %0d ns with %0d of %0d responses checked",
                 timeout_ns, resp_count, stim_q.size());
        abort_run();
    end : watchdog

    initial begin : stimulus
        int idx;
        clk_i        = 1'b0;
        rst_n_i      = 1'b0;
        req_valid_i  = 1'b0;
        req_i        = '0;
        resp_ready_i = 1'b0;
        idx          = 0;

        // Directed corner cases first, then the LCG mix
        add_request(SUB,   32'h0000_0000, 32'h0000_0001, '0, 32'h0000_0100, 5'd1, 1'b0);
        add_request(SRA,   32'h8000_0000, 32'h0000_0024, '0, 32'h0000_0104, 5'd2, 1'b0);
        add_request(SRAI,  32'h8000_0001, '0, 32'hFFFF_FFFF, 32'h0000_0108, 5'd3, 1'b0);
        add_request(SLL,   32'h0000_0001, 32'hFFFF_FFE3, '0, 32'h0000_010C, 5'd4, 1'b0);
        add_request(SLT,   32'h0000_0001, 32'hFFFF_FFFF, '0, 32'h0000_0110, 5'd5, 1'b0);
        add_request(SLTU,  32'h0000_0001, 32'hFFFF_FFFF, '0, 32'h0000_0114, 5'd6, 1'b0);
        add_request(SLTI,  32'hFFFF_FFFB, '0, 32'h0000_0003, 32'h0000_0118, 5'd7, 1'b0);
        add_request(SLTIU, 32'h0000_0005, '0, 32'hFFFF_FFFF, 32'h0000_011C, 5'd8, 1'b0);
        add_request(BEQ,   32'h0000_1234, 32'h0000_1234, 32'hFFFF_FFF0, 32'h0000_0200, 5'd9, 1'b0);
        add_request(BGEU,  32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0010, 32'h0000_0204, 5'd9, 1'b0);
        add_request(BLT,   32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0006, 32'h0000_0208, 5'd9, 1'b0);
        add_request(JAL,   '0, '0, 32'h0000_0040, 32'h0000_0300, 5'd1, 1'b1);
        add_request(JAL,   '0, '0, 32'h0000_0040, 32'h0000_0304, 5'd1, 1'b0);
        add_request(JALR,  32'h0000_1003, '0, 32'h0000_0000, 32'h0000_0400, 5'd5, 1'b0);
        add_request(ADD,   32'h0000_0005, 32'h0000_0007, '0, 32'h0000_0404, 5'd0, 1'b0);
        add_request(LUI,   '0, '0, 32'hABCD_E000, 32'h0000_0408, 5'd10, 1'b0);
        add_request(AUIPC, '0, '0, 32'h0000_1000, 32'h0000_0500, 5'd11, 1'b0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            stim_q.push_back(random_request());
        end
        stim_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;

        // One request is held until its transfer, with random gaps and back-pressure
        while (idx < stim_q.size() || req_valid_i || exp_q.size() != 0) begin
            @(posedge clk_i);
            #2;
            resp_ready_i = (next_random() % 32'd4) != 32'd0;
            if (req_valid_i && req_fire) begin
                req_valid_i = 1'b0;
            end
            if (!req_valid_i && idx < stim_q.size() && (next_random() % 32'd5) != 32'd0) begin
                req_i       = stim_q[idx];
                req_valid_i = 1'b1;
                idx++;
            end
        end

        if (resp_count != stim_q.size() || push_count != stim_q.size()) begin
            $display("Sent %0d requests, accepted %0d, checked %0d responses",
                     stim_q.size(), push_count, resp_count);
            abort_run();
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end : stimulus

endmodule : execute_unit_tb

`default_nettype wire

// File: sim.f
hdl/exec_pkg.sv
hdl/operand_select.sv
hdl/arithmetic_logic_unit.sv
hdl/branch_resolver.sv
hdl/execute_control.sv
hdl/execute_unit.sv
tb/execute_unit_properties.sv
tb/execute_unit_tb.sv

// File: Makefile
# Verilator flow for the execute stage testbench
# Override any variable on the command line, e.g. make run C_EXT_EN=0

TOP       ?= execute_unit_tb
BUILD_DIR ?= build
LOG       ?= sim.log
C_EXT_EN  ?= 1
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -sv

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GC_EXT_EN=$(C_EXT_EN) \
		-Mdir $(BUILD_DIR) -o V$(TOP) -f sim.f

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
